//--- common/noc_pkg.sv
// noc router shared types
package noc_pkg;

   localparam int num_ports        = 4;
   localparam int bytes_per_packet = 4;

   typedef logic [7:0] byte_t;
   typedef logic [3:0] node_id_t;
   typedef logic [1:0] beat_t;
   typedef logic [1:0] src_sel_t;   // candidate 0..2 of an output

   typedef struct packed {
      node_id_t    src;
      node_id_t    dest;
      logic [23:0] data;
   } packet_fields_t;

   // byte 0 sits in bits 31:24 and travels first
   typedef union packed {
      byte_t [0:bytes_per_packet-1] bytes;
      packet_fields_t               fields;
   } packet_t;

   typedef struct packed {
      logic    valid;
      packet_t pkt;
   } in_slot_t;

   typedef struct packed {
      logic     load;
      src_sel_t src_sel;
   } grant_t;

   // fixed routing tables of the two routers in the mesh
   function automatic int route_port(input int router_id, input node_id_t dest);
      int port;
      if (router_id == 0) begin
         case (dest)
            4'd0:    port = 0;
            4'd1:    port = 2;
            4'd2:    port = 3;
            default: port = 1;
         endcase
      end else begin
         case (dest)
            4'd3:    port = 0;
            4'd4:    port = 1;
            4'd5:    port = 2;
            default: port = 3;   // everything else leaves toward router 0
         endcase
      end
      return port;
   endfunction

endpackage

//--- source/beat_fsm.sv
// four beat transfer sequencer
`timescale 1ns/1ps

module beat_fsm (
   input  logic          clk,
   input  logic          rst_b,
   input  logic          start,
   output logic          busy,
   output logic          done,
   output noc_pkg::beat_t beat
);

   typedef enum logic {
      st_idle,
      st_busy
   } state_t;

   localparam noc_pkg::beat_t last_beat = noc_pkg::beat_t'(noc_pkg::bytes_per_packet - 1);

   state_t state;

   assign busy = (state == st_busy);
   assign done = busy && (beat == last_beat);

   // beat stays 0 while idle so the start cycle carries byte 0
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         state <= st_idle;
         beat  <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_busy;
                  beat  <= noc_pkg::beat_t'(1);
               end
            end
            st_busy: begin
               if (done) begin
                  state <= st_idle;
                  beat  <= '0;
               end else begin
                  beat <= beat + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   a_no_restart: assert property (@(posedge clk) disable iff (!rst_b) start |-> !busy)
      else $error("beat_fsm started while busy");

endmodule

//--- port/port_receiver.sv
// inbound port receiver
`timescale 1ns/1ps

module port_receiver (
   input  logic              clk,
   input  logic              rst_b,
   input  logic              put,
   input  noc_pkg::byte_t    payload,
   input  logic              slot_release,
   output logic              free,
   output noc_pkg::in_slot_t slot
);

   logic             busy;
   logic             done;
   noc_pkg::beat_t   beat;
   logic             valid;
   noc_pkg::packet_t pkt;

   beat_fsm u_beat_fsm (
      .clk   (clk),
      .rst_b (rst_b),
      .start (put),
      .busy  (busy),
      .done  (done),
      .beat  (beat)
   );

   // byte lane capture
   always_ff @(posedge clk) begin
      if (put || busy) begin
         pkt.bytes[beat] <= payload;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         free  <= 1'b1;
         valid <= 1'b0;
      end else begin
         if (put) begin
            free <= 1'b0;
         end else if (slot_release) begin
            free <= 1'b1;   // sender may start the next packet
         end
         if (done) begin
            valid <= 1'b1;
         end else if (slot_release) begin
            valid <= 1'b0;
         end
      end
   end

   assign slot.valid = valid;
   assign slot.pkt   = pkt;

   a_put_when_free: assert property (@(posedge clk) disable iff (!rst_b) put |-> free)
      else $error("put_inbound while port not free");

endmodule

//--- port/port_transmitter.sv
// outbound port transmitter
`timescale 1ns/1ps

module port_transmitter (
   input  logic             clk,
   input  logic             rst_b,
   input  noc_pkg::packet_t grant_pkt,
   input  logic             load,
   input  logic             free_out,
   output logic             full,
   output logic             put,
   output noc_pkg::byte_t   payload
);

   logic             start;
   logic             busy;
   logic             done;
   noc_pkg::beat_t   beat;
   noc_pkg::packet_t pkt_buf;

   assign start = full && free_out && !busy;   // first beat waits on downstream

   beat_fsm u_beat_fsm (
      .clk   (clk),
      .rst_b (rst_b),
      .start (start),
      .busy  (busy),
      .done  (done),
      .beat  (beat)
   );

   always_ff @(posedge clk) begin
      if (load) begin
         pkt_buf <= grant_pkt;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         full <= 1'b0;
      end else if (load) begin
         full <= 1'b1;
      end else if (done) begin
         full <= 1'b0;
      end
   end

   assign put     = busy || start;
   assign payload = pkt_buf.bytes[beat];

   a_no_load_full: assert property (@(posedge clk) disable iff (!rst_b) load |-> !full)
      else $error("packet loaded into a full outbound buffer");

endmodule

//--- route/grant_pointer.sv
// round robin pointer for one output
`timescale 1ns/1ps

module grant_pointer (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    advance,
   output noc_pkg::src_sel_t [2:0] order
);

   noc_pkg::src_sel_t ptr;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ptr <= '0;
      end else if (advance) begin
         ptr <= (ptr == 2'd2) ? 2'd0 : ptr + 2'd1;   // wraps after candidate 2
      end
   end

   // search order, modulo 3
   always_comb begin
      order[0] = ptr;
      order[1] = (ptr == 2'd2) ? 2'd0 : ptr + 2'd1;
      order[2] = (ptr == 2'd0) ? 2'd2 : ptr - 2'd1;
   end

endmodule

//--- route/output_arbiter.sv
// output port arbiter
`timescale 1ns/1ps

module output_arbiter #(
   parameter int router_id = 0,
   parameter int out_port  = 0
) (
   input  logic                    clk,
   input  logic                    rst_b,
   input  noc_pkg::in_slot_t [2:0] cand,
   input  logic                    full,
   output noc_pkg::grant_t         grant,
   output noc_pkg::packet_t        grant_pkt
);

   noc_pkg::src_sel_t [2:0] order;
   logic [2:0]              eligible;
   logic                    found;
   noc_pkg::src_sel_t       pick;

   grant_pointer u_grant_pointer (
      .clk     (clk),
      .rst_b   (rst_b),
      .advance (grant.load),
      .order   (order)
   );

   // candidates whose destination maps onto this output
   always_comb begin
      for (int c = 0; c < 3; c++) begin
         eligible[c] = cand[c].valid &&
                       (noc_pkg::route_port(router_id, cand[c].pkt.fields.dest) == out_port);
      end
   end

   always_comb begin
      found = 1'b0;
      pick  = order[0];
      for (int j = 0; j < 3; j++) begin
         if (!found && eligible[order[j]]) begin
            found = 1'b1;
            pick  = order[j];
         end
      end
   end

   assign grant.load    = found && !full;
   assign grant.src_sel = pick;
   assign grant_pkt     = cand[pick].pkt;

   a_grant_valid: assert property (@(posedge clk) disable iff (!rst_b)
                                   grant.load |-> cand[grant.src_sel].valid)
      else $error("grant to an invalid candidate");

endmodule

//--- route/route_crossbar.sv
// crossbar with per-output arbitration
`timescale 1ns/1ps

module route_crossbar #(
   parameter int router_id = 0
) (
   input  logic                                          clk,
   input  logic                                          rst_b,
   input  noc_pkg::in_slot_t [noc_pkg::num_ports-1:0]    slots,
   input  logic [noc_pkg::num_ports-1:0]                 full,
   output logic [noc_pkg::num_ports-1:0]                 load,
   output noc_pkg::packet_t [noc_pkg::num_ports-1:0]     out_pkt,
   output logic [noc_pkg::num_ports-1:0]                 slot_release
);

   noc_pkg::grant_t [noc_pkg::num_ports-1:0] grants;

   for (genvar k = 0; k < noc_pkg::num_ports; k++) begin : g_out
      noc_pkg::in_slot_t [2:0] cand;

      // output k looks at inputs k+1, k+2, k+3
      for (genvar c = 0; c < 3; c++) begin : g_cand
         assign cand[c] = slots[(k + c + 1) % noc_pkg::num_ports];
      end

      output_arbiter #(
         .router_id (router_id),
         .out_port  (k)
      ) u_output_arbiter (
         .clk       (clk),
         .rst_b     (rst_b),
         .cand      (cand),
         .full      (full[k]),
         .grant     (grants[k]),
         .grant_pkt (out_pkt[k])
      );

      assign load[k] = grants[k].load;
   end

   // map each grant back to its input
   always_comb begin
      slot_release = '0;
      for (int k = 0; k < noc_pkg::num_ports; k++) begin
         if (grants[k].load) begin
            slot_release[(k + int'(grants[k].src_sel) + 1) % noc_pkg::num_ports] = 1'b1;
         end
      end
   end

endmodule

//--- source/noc_router.sv
// four port noc router
`timescale 1ns/1ps

module noc_router #(
   parameter int router_id = 0
) (
   input  logic                                       clk,
   input  logic                                       rst_b,
   output logic [noc_pkg::num_ports-1:0]              free_inbound,
   input  logic [noc_pkg::num_ports-1:0]              put_inbound,
   input  noc_pkg::byte_t [noc_pkg::num_ports-1:0]    payload_inbound,
   input  logic [noc_pkg::num_ports-1:0]              free_outbound,
   output logic [noc_pkg::num_ports-1:0]              put_outbound,
   output noc_pkg::byte_t [noc_pkg::num_ports-1:0]    payload_outbound
);

   noc_pkg::in_slot_t [noc_pkg::num_ports-1:0] slots;
   noc_pkg::packet_t [noc_pkg::num_ports-1:0]  out_pkt;
   logic [noc_pkg::num_ports-1:0]              slot_release;
   logic [noc_pkg::num_ports-1:0]              load;
   logic [noc_pkg::num_ports-1:0]              full;

   for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_in
      port_receiver u_port_receiver (
         .clk          (clk),
         .rst_b        (rst_b),
         .put          (put_inbound[p]),
         .payload      (payload_inbound[p]),
         .slot_release (slot_release[p]),
         .free         (free_inbound[p]),
         .slot         (slots[p])
      );
   end

   route_crossbar #(
      .router_id (router_id)
   ) u_route_crossbar (
      .clk          (clk),
      .rst_b        (rst_b),
      .slots        (slots),
      .full         (full),
      .load         (load),
      .out_pkt      (out_pkt),
      .slot_release (slot_release)
   );

   for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_out
      port_transmitter u_port_transmitter (
         .clk       (clk),
         .rst_b     (rst_b),
         .grant_pkt (out_pkt[p]),
         .load      (load[p]),
         .free_out  (free_outbound[p]),
         .full      (full[p]),
         .put       (put_outbound[p]),
         .payload   (payload_outbound[p])
      );
   end

endmodule

//--- dv/noc_router_tb.sv
// noc router testbench
`timescale 1ns/1ps

module noc_router_tb;

   localparam int timeout_cycles = 200;

   logic                                    clk;
   logic                                    rst_b;
   logic [noc_pkg::num_ports-1:0]           free_inbound;
   logic [noc_pkg::num_ports-1:0]           put_inbound;
   noc_pkg::byte_t [noc_pkg::num_ports-1:0] payload_inbound;
   logic [noc_pkg::num_ports-1:0]           free_outbound;
   logic [noc_pkg::num_ports-1:0]           put_outbound;
   noc_pkg::byte_t [noc_pkg::num_ports-1:0] payload_outbound;

   integer seed;

   noc_router #(
      .router_id (0)
   ) u_noc_router (
      .clk              (clk),
      .rst_b            (rst_b),
      .free_inbound     (free_inbound),
      .put_inbound      (put_inbound),
      .payload_inbound  (payload_inbound),
      .free_outbound    (free_outbound),
      .put_outbound     (put_outbound),
      .payload_outbound (payload_outbound)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic reset_dut();
      @(negedge clk);
      rst_b = 1'b0;
      repeat (10) @(negedge clk);
      rst_b = 1'b1;
   endtask

   // src field carries the input number
   function automatic noc_pkg::packet_t make_packet(input int src, input int dest);
      noc_pkg::packet_t pkt;
      pkt.fields.src  = noc_pkg::node_id_t'(src);
      pkt.fields.dest = noc_pkg::node_id_t'(dest);
      pkt.fields.data = 24'($random(seed));
      return pkt;
   endfunction

   task automatic send_packet(input int port, input noc_pkg::packet_t pkt);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!free_inbound[port]) begin
         if (waited >= timeout_cycles) begin
            stop_run($sformatf("timeout waiting for free_inbound on port %0d", port));
         end
         waited++;
         @(negedge clk);
      end
      for (int b = 0; b < noc_pkg::bytes_per_packet; b++) begin
         put_inbound[port]     = (b == 0);   // strobe only with byte 0
         payload_inbound[port] = pkt.bytes[b];
         @(negedge clk);
      end
      put_inbound[port]     = 1'b0;
      payload_inbound[port] = '0;
   endtask

   task automatic collect_packet(input int port, output noc_pkg::packet_t pkt);
      int waited;
      waited = 0;
      @(posedge clk);
      while (!put_outbound[port]) begin
         if (waited >= timeout_cycles) begin
            stop_run($sformatf("timeout waiting for put_outbound on port %0d", port));
         end
         waited++;
         @(posedge clk);
      end
      pkt.bytes[0] = payload_outbound[port];
      for (int b = 1; b < noc_pkg::bytes_per_packet; b++) begin
         @(posedge clk);
         check_value($sformatf("put_outbound[%0d]", port), put_outbound[port], 1'b1);
         pkt.bytes[b] = payload_outbound[port];
      end
   endtask

   // output stays silent and the blocked input stays busy
   task automatic expect_held(input int cycles, input int out_port, input int in_port);
      repeat (cycles) begin
         @(posedge clk);
         check_value($sformatf("put_outbound[%0d]", out_port), put_outbound[out_port], 1'b0);
         check_value($sformatf("free_inbound[%0d]", in_port), free_inbound[in_port], 1'b0);
      end
   endtask

   task automatic reset_state_check();
      @(negedge clk);
      check_value("free_inbound", free_inbound, 4'hf);
      check_value("put_outbound", put_outbound, 4'h0);
   endtask

   task automatic single_route(input int src_in, input int dest, input int exp_out);
      noc_pkg::packet_t sent;
      noc_pkg::packet_t got;
      sent = make_packet(src_in, dest);
      send_packet(src_in, sent);
      collect_packet(exp_out, got);
      check_value($sformatf("payload_outbound[%0d]", exp_out), got, sent);
      @(negedge clk);
      check_value($sformatf("free_inbound[%0d]", src_in), free_inbound[src_in], 1'b1);
   endtask

   task automatic back_pressure();
      noc_pkg::packet_t first;
      noc_pkg::packet_t second;
      noc_pkg::packet_t got;
      first  = make_packet(0, 1);
      second = make_packet(3, 1);
      @(negedge clk);
      free_outbound[2] = 1'b0;
      send_packet(0, first);   // parks in the port 2 buffer
      send_packet(3, second);
      expect_held(12, 2, 3);
      @(negedge clk);
      free_outbound[2] = 1'b1;
      collect_packet(2, got);
      check_value("payload_outbound[2] first", got, first);
      collect_packet(2, got);
      check_value("payload_outbound[2] second", got, second);
      @(negedge clk);
      check_value("free_inbound[3]", free_inbound[3], 1'b1);
   endtask

   task automatic round_robin_order();
      noc_pkg::packet_t sent [1:3];
      noc_pkg::packet_t got;
      reset_dut();   // pointers back to candidate 0
      for (int s = 1; s <= 3; s++) begin
         sent[s] = make_packet(s, 0);
      end
      @(negedge clk);
      free_outbound[0] = 1'b0;
      fork
         send_packet(1, sent[1]);
         send_packet(2, sent[2]);
         send_packet(3, sent[3]);
      join
      expect_held(8, 0, 3);
      @(negedge clk);
      free_outbound[0] = 1'b1;
      for (int s = 1; s <= 3; s++) begin
         collect_packet(0, got);
         check_value("src field on port 0", got.fields.src, s);
         check_value("payload_outbound[0]", got, sent[s]);
      end
   endtask

   // inputs 0..3 to outputs 2, 3, 0, 1
   task automatic parallel_paths();
      noc_pkg::packet_t sent [0:3];
      noc_pkg::packet_t got [0:3];
      int               dest [0:3];
      int               out_port [0:3];
      dest     = '{1, 2, 0, 9};
      out_port = '{2, 3, 0, 1};
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         sent[i] = make_packet(i, dest[i]);
      end
      fork
         send_packet(0, sent[0]);
         send_packet(1, sent[1]);
         send_packet(2, sent[2]);
         send_packet(3, sent[3]);
         collect_packet(2, got[0]);
         collect_packet(3, got[1]);
         collect_packet(0, got[2]);
         collect_packet(1, got[3]);
      join
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
         check_value($sformatf("payload_outbound[%0d]", out_port[i]), got[i], sent[i]);
      end
   endtask

   initial begin
      seed            = 32'hdd33;
      rst_b           = 1'b0;
      put_inbound     = '0;
      payload_inbound = '0;
      free_outbound   = '1;
      reset_dut();
      reset_state_check();
      single_route(2, 0, 0);
      single_route(0, 1, 2);
      single_route(1, 2, 3);
      single_route(0, 9, 1);
      back_pressure();
      round_robin_order();
      parallel_paths();
      $display("sim passed");
      $finish;
   end

endmodule

//--- noc_router.f
common/noc_pkg.sv
source/beat_fsm.sv
port/port_receiver.sv
port/port_transmitter.sv
route/grant_pointer.sv
route/output_arbiter.sv
route/route_crossbar.sv
source/noc_router.sv
dv/noc_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the noc router testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module noc_router_tb \
   -f noc_router.f -o noc_router_sim &&
   ./obj_dir/noc_router_sim > sim.log 2>&1 ||
   echo "build or simulation step returned an error"

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log 2>/dev/null && echo "RESULT: PASS" && exit 0
echo "RESULT: FAIL"
exit 1
